// File: Makefile
TOP := tb_lsu
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/addr_stage.sv
`timescale 1ns/1ps

module addr_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue_valid,
	input  core_pkg::issue_t   issue,
	output core_pkg::reg_idx_t rs_base_idx,
	output core_pkg::reg_idx_t rs_data_idx,
	input  logic [31:0]        base_val,
	input  logic [31:0]        data_val,
	output core_pkg::agu_t     agu
);

	logic [31:0] wr_sel;

	assign rs_base_idx = issue.rs_base;
	assign rs_data_idx = issue.rs_data;

	// The data slot carries the result for ops that skip the bus.
	always_comb begin
		case (issue.opcode)
			core_pkg::OP_LDI:  wr_sel = issue.imm;
			core_pkg::OP_MOVE: wr_sel = base_val;
			default:           wr_sel = data_val;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			agu.valid <= 1'b0;
		end else begin
			agu.valid <= issue_valid; // One cycle per strobe.
			if (issue_valid) begin
				agu.opcode  <= issue.opcode;
				agu.rd      <= issue.rd;
				agu.addr    <= base_val + issue.imm;
				agu.wr_data <= wr_sel;
				agu.width   <= issue.width;
			end
		end
	end

endmodule

// File: hdl/bus_pkg.sv
package bus_pkg;

	localparam int MEM_WORDS = 256;
	localparam int MEM_AW = $clog2(MEM_WORDS); // Word address bits, taken from addr[9:2].

	typedef enum logic [1:0] {
		W_BYTE = 2'd0,
		W_HALF = 2'd1,
		W_WORD = 2'd2
	} width_t;

	// Request toward the data RAM. Address is always word aligned.
	typedef struct packed {
		logic        access;
		logic        wr_en;
		logic [31:0] addr;
		logic [3:0]  bytesel;
		logic [31:0] wr_val;
	} bus_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] data; // Full word, lanes unshifted.
	} bus_rsp_t;

endpackage

// File: hdl/core_pkg.sv
package core_pkg;

	localparam int NUM_REGS = 16;

	typedef enum logic [2:0] {
		OP_NOP   = 3'd0,
		OP_LDI   = 3'd1,
		OP_MOVE  = 3'd2,
		OP_LOAD  = 3'd3,
		OP_STORE = 3'd4
	} opcode_t;

	typedef logic [3:0] reg_idx_t;

	// Op as handed over by issue.
	typedef struct packed {
		opcode_t         opcode;
		reg_idx_t        rd;
		reg_idx_t        rs_base;
		reg_idx_t        rs_data;
		logic [31:0]     imm;
		bus_pkg::width_t width;
	} issue_t;

	// Registered output of the address stage.
	typedef struct packed {
		logic            valid;
		opcode_t         opcode;
		reg_idx_t        rd;
		logic [31:0]     addr;    // Byte address, not yet aligned.
		logic [31:0]     wr_data; // Store data, or the result of ldi/move.
		bus_pkg::width_t width;
	} agu_t;

	typedef struct packed {
		logic        valid;
		reg_idx_t    rd;
		logic [31:0] value;
	} wb_t;

endpackage

// File: hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::bus_req_t req,
	output bus_pkg::bus_rsp_t rsp
);

	logic [3:0][7:0]            mem [bus_pkg::MEM_WORDS];
	logic [bus_pkg::MEM_AW-1:0] idx;
	logic                       ack_q;
	logic [31:0]                data_q;

	assign idx = req.addr[bus_pkg::MEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (req.access) begin
			if (req.wr_en) begin
				for (int i = 0; i < 4; i++) begin
					if (req.bytesel[i]) begin
						mem[idx][i] <= req.wr_val[8*i +: 8];
					end
				end
			end
			data_q <= mem[idx]; // Old contents on a write, unused then.
		end
	end

	// Every access is acknowledged on the following cycle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req.access;
		end
	end

	assign rsp = '{ack: ack_q, data: data_q};

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue_valid,
	input  core_pkg::issue_t   issue,
	input  logic               dbg_en,
	input  logic               dbg_access,
	input  logic               dbg_wr_en,
	input  logic [31:0]        dbg_addr,
	input  bus_pkg::width_t    dbg_width,
	input  logic [31:0]        dbg_wr_val,
	output logic [31:0]        dbg_rd_val,
	output logic               dbg_compl,
	output logic               retire_valid,
	output core_pkg::reg_idx_t retire_rd,
	output logic [31:0]        retire_value
);

	core_pkg::reg_idx_t rs_base_idx;
	core_pkg::reg_idx_t rs_data_idx;
	logic [31:0]        base_val;
	logic [31:0]        data_val;
	core_pkg::agu_t     agu;
	bus_pkg::bus_req_t  req;
	bus_pkg::bus_rsp_t  rsp;
	core_pkg::wb_t      wb;
	core_pkg::wb_t      rf_wr;

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (rs_base_idx),
		.rd_addr_b (rs_data_idx),
		.rd_data_a (base_val),
		.rd_data_b (data_val),
		.wr        (rf_wr)
	);

	addr_stage u_addr_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue       (issue),
		.rs_base_idx (rs_base_idx),
		.rs_data_idx (rs_data_idx),
		.base_val    (base_val),
		.data_val    (data_val),
		.agu         (agu)
	);

	mem_stage u_mem_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.agu        (agu),
		.dbg_en     (dbg_en),
		.dbg_access (dbg_access),
		.dbg_wr_en  (dbg_wr_en),
		.dbg_addr   (dbg_addr),
		.dbg_width  (dbg_width),
		.dbg_wr_val (dbg_wr_val),
		.dbg_rd_val (dbg_rd_val),
		.dbg_compl  (dbg_compl),
		.req        (req),
		.rsp        (rsp),
		.wb         (wb)
	);

	data_ram u_data_ram (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.rsp   (rsp)
	);

	wb_stage u_wb_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.wb_in        (wb),
		.rf_wr        (rf_wr),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_value (retire_value)
	);

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  core_pkg::agu_t    agu,
	input  logic              dbg_en,
	input  logic              dbg_access,
	input  logic              dbg_wr_en,
	input  logic [31:0]       dbg_addr,
	input  bus_pkg::width_t   dbg_width,
	input  logic [31:0]       dbg_wr_val,
	output logic [31:0]       dbg_rd_val,
	output logic              dbg_compl,
	output bus_pkg::bus_req_t req,
	input  bus_pkg::bus_rsp_t rsp,
	output core_pkg::wb_t     wb
);

	logic [31:0]        wr_data;
	logic [1:0]         byte_addr;
	bus_pkg::width_t    mem_width;
	logic               pipe_mem;
	logic               pipe_byp;
	logic               ld_q;
	logic               dbg_q;
	logic               byp_q;
	core_pkg::reg_idx_t rd_q;
	logic [31:0]        byp_val_q;
	bus_pkg::width_t    acc_width_q;
	logic [1:0]         acc_off_q;
	logic [31:0]        rd_val;

	assign pipe_mem = agu.valid &&
		(agu.opcode == core_pkg::OP_LOAD || agu.opcode == core_pkg::OP_STORE);
	assign pipe_byp = agu.valid &&
		(agu.opcode == core_pkg::OP_LDI || agu.opcode == core_pkg::OP_MOVE);

	// Debug owns the bus while enabled.
	always_comb begin
		if (dbg_en) begin
			wr_data    = dbg_wr_val;
			byte_addr  = dbg_addr[1:0];
			mem_width  = dbg_width;
			req.access = dbg_access;
			req.wr_en  = dbg_wr_en;
			req.addr   = {dbg_addr[31:2], 2'b00};
		end else begin
			wr_data    = agu.wr_data;
			byte_addr  = agu.addr[1:0];
			mem_width  = agu.width;
			req.access = pipe_mem;
			req.wr_en  = (agu.opcode == core_pkg::OP_STORE);
			req.addr   = {agu.addr[31:2], 2'b00};
		end

		// Byte selects and write data rotated into the lane.
		case (mem_width)
			bus_pkg::W_HALF: begin
				req.bytesel = 4'b0011 << {byte_addr[1], 1'b0};
				req.wr_val  = wr_data << {byte_addr[1], 4'b0000};
			end
			bus_pkg::W_BYTE: begin
				req.bytesel = 4'b0001 << byte_addr;
				req.wr_val  = wr_data << {byte_addr, 3'b000};
			end
			default: begin
				req.bytesel = 4'b1111;
				req.wr_val  = wr_data;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_q  <= 1'b0;
			dbg_q <= 1'b0;
			byp_q <= 1'b0;
		end else begin
			ld_q  <= !dbg_en && agu.valid && agu.opcode == core_pkg::OP_LOAD;
			dbg_q <= dbg_en && dbg_access;
			byp_q <= !dbg_en && pipe_byp;
			if (req.access) begin
				acc_width_q <= mem_width; // Needed to align the returning word.
				acc_off_q   <= byte_addr;
			end
			if (pipe_mem || pipe_byp) begin
				rd_q      <= agu.rd;
				byp_val_q <= agu.wr_data;
			end
		end
	end

	// Read data shifted down and zero extended.
	always_comb begin
		case (acc_width_q)
			bus_pkg::W_HALF: rd_val = (rsp.data >> {acc_off_q[1], 4'b0000}) & 32'h0000_ffff;
			bus_pkg::W_BYTE: rd_val = (rsp.data >> {acc_off_q, 3'b000}) & 32'h0000_00ff;
			default:         rd_val = rsp.data;
		endcase
	end

	assign dbg_rd_val = rd_val;
	assign dbg_compl  = dbg_q && rsp.ack;

	// Loads and bypassed ops never land in the same cycle.
	always_comb begin
		wb.valid = (ld_q && rsp.ack) || byp_q;
		wb.rd    = rd_q;
		wb.value = ld_q ? rd_val : byp_val_q;
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::reg_idx_t rd_addr_a,
	input  core_pkg::reg_idx_t rd_addr_b,
	output logic [31:0]        rd_data_a,
	output logic [31:0]        rd_data_b,
	input  core_pkg::wb_t      wr
);

	logic [31:0] regs [core_pkg::NUM_REGS];

	// Entry zero is never written.
	always_ff @(posedge clk) begin
		if (rst_n && wr.valid && wr.rd != '0) begin
			regs[wr.rd] <= wr.value;
		end
	end

	assign rd_data_a = (rd_addr_a == '0) ? 32'd0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? 32'd0 : regs[rd_addr_b];

endmodule

// File: hdl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::wb_t      wb_in,
	output core_pkg::wb_t      rf_wr,
	output logic               retire_valid,
	output core_pkg::reg_idx_t retire_rd,
	output logic [31:0]        retire_value
);

	core_pkg::wb_t wb_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_q.valid <= 1'b0;
		end else begin
			wb_q.valid <= wb_in.valid;
			if (wb_in.valid) begin
				wb_q.rd    <= wb_in.rd;
				wb_q.value <= wb_in.value;
			end
		end
	end

	assign rf_wr = wb_q; // Register file takes it on the next edge.

	assign retire_valid = wb_q.valid;
	assign retire_rd    = wb_q.rd;
	assign retire_value = wb_q.value;

endmodule

// File: list.f
hdl/bus_pkg.sv
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/addr_stage.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/wb_stage.sv
hdl/lsu_top.sv
verif/lsu_asserts.sv
verif/tb_lsu.sv

// File: verif/lsu_asserts.sv
`timescale 1ns/1ps

module lsu_asserts (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input logic dbg_en,
	input logic retire_valid,
	input logic access,
	input logic wr_en,
	input logic ack,
	input logic wb_valid,
	input logic dbg_compl
);

	int n_issue_fail = 0;
	int n_unknown_fail = 0;
	int n_ack_fail = 0;

	// Debug owns the bus alone.
	no_issue_in_debug: assert property (@(posedge clk) disable iff (!rst_n)
		!(issue_valid && dbg_en))
	else begin
		n_issue_fail++;
		$error("issue strobe while debug is enabled");
	end

	retire_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(retire_valid))
	else begin
		n_unknown_fail++;
		$error("retire_valid is unknown");
	end

	// Each access is acked on the next cycle and completes toward the side that asked.
	ack_next_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		access |=> ack && (wb_valid || dbg_compl || $past(wr_en && !dbg_en)))
	else begin
		n_ack_fail++;
		$error("bus access without ack or completion in the next cycle");
	end

endmodule

// File: verif/lsu_patterns.txt
// kind: 0 pipeline op, 1 debug write, 2 debug read, f end of patterns
// kind op rd rs_base rs_data imm/addr width value gap (op 1 ldi 2 move 3 load 4 store)
0 1 1 0 0 12345678 2 12345678 3
0 2 2 1 0 00000000 2 12345678 0
0 4 0 0 1 00000040 2 00000000 0
0 3 3 0 0 00000040 2 12345678 0
// Byte lanes, upper bits of the source registers must not leak.
0 1 4 0 0 777777a1 2 777777a1 0
0 1 5 0 0 000000b2 2 000000b2 0
0 1 6 0 0 ffffffc3 2 ffffffc3 0
0 1 7 0 0 000000d4 2 000000d4 3
0 4 0 0 4 00000080 0 00000000 0
0 4 0 0 5 00000081 0 00000000 0
0 4 0 0 6 00000082 0 00000000 0
0 4 0 0 7 00000083 0 00000000 0
0 3 8 0 0 00000080 2 d4c3b2a1 0
0 3 9 0 0 00000081 0 000000b2 0
0 3 a 0 0 00000083 0 000000d4 0
0 3 b 0 0 00000080 0 000000a1 0
0 3 c 0 0 00000082 0 000000c3 0
// Halfwords.
0 4 0 0 1 000000c0 2 00000000 0
0 4 0 0 4 000000c2 1 00000000 0
0 3 d 0 0 000000c0 1 00005678 0
0 3 e 0 0 000000c2 1 000077a1 0
0 4 0 0 6 000000c0 1 00000000 0
0 3 f 0 0 000000c0 2 77a1ffc3 1
1 0 0 0 0 00000100 2 cafef00d 0
2 0 0 0 0 000000c2 1 000077a1 0
0 3 3 0 0 00000100 2 cafef00d 0
0 4 0 0 7 00000101 0 00000000 1
2 0 0 0 0 00000100 2 cafed40d 0
// Register zero stays zero.
0 1 0 0 0 00000055 2 00000055 3
0 2 9 0 0 00000000 2 00000000 0
f 0 0 0 0 00000000 0 00000000 0

// File: verif/tb_lsu.sv
`timescale 1ns/1ps

bind lsu_top lsu_asserts u_lsu_asserts (
	.clk          (clk),
	.rst_n        (rst_n),
	.issue_valid  (issue_valid),
	.dbg_en       (dbg_en),
	.retire_valid (retire_valid),
	.access       (req.access),
	.wr_en        (req.wr_en),
	.ack          (rsp.ack),
	.wb_valid     (wb.valid),
	.dbg_compl    (dbg_compl)
);

module tb_lsu;

	localparam int NCOL = 9; // kind op rd rs_base rs_data imm width value gap
	localparam int MAX_LINES = 64;
	localparam int CLK_PERIOD = 20;

	typedef struct packed {
		logic [31:0]        due;
		core_pkg::reg_idx_t rd;
		logic [31:0]        value;
	} retire_exp_t;

	logic               clk;
	logic               rst_n;
	logic               issue_valid;
	core_pkg::issue_t   issue;
	logic               dbg_en;
	logic               dbg_access;
	logic               dbg_wr_en;
	logic [31:0]        dbg_addr;
	bus_pkg::width_t    dbg_width;
	logic [31:0]        dbg_wr_val;
	logic [31:0]        dbg_rd_val;
	logic               dbg_compl;
	logic               retire_valid;
	core_pkg::reg_idx_t retire_rd;
	logic [31:0]        retire_value;

	logic [31:0] pat [MAX_LINES*NCOL];
	retire_exp_t exp_q [$];
	int          n_lines = 0;
	int          cur_line = 0;
	int          cycle = 0;
	int          drv_chk = 0;
	int          drv_err = 0;
	int          ret_chk = 0;
	int          ret_err = 0;
	logic        loaded = 1'b0;

	lsu_top u_lsu_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.dbg_en       (dbg_en),
		.dbg_access   (dbg_access),
		.dbg_wr_en    (dbg_wr_en),
		.dbg_addr     (dbg_addr),
		.dbg_width    (dbg_width),
		.dbg_wr_val   (dbg_wr_val),
		.dbg_rd_val   (dbg_rd_val),
		.dbg_compl    (dbg_compl),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_value (retire_value)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic next_slot();
		@(posedge clk);
		#2;
	endtask

	task automatic run_op(input int b);
		core_pkg::issue_t op;
		op.opcode   = core_pkg::opcode_t'(pat[b+1][2:0]);
		op.rd       = pat[b+2][3:0];
		op.rs_base  = pat[b+3][3:0];
		op.rs_data  = pat[b+4][3:0];
		op.imm      = pat[b+5];
		op.width    = bus_pkg::width_t'(pat[b+6][1:0]);
		issue       = op;
		issue_valid = 1'b1;
		next_slot();
		issue_valid = 1'b0;
	endtask

	task automatic run_debug(input int b);
		logic is_read;
		is_read    = (pat[b] == 32'd2);
		dbg_en     = 1'b1;
		dbg_access = 1'b1;
		dbg_wr_en  = !is_read;
		dbg_addr   = pat[b+5];
		dbg_width  = bus_pkg::width_t'(pat[b+6][1:0]);
		dbg_wr_val = is_read ? 32'd0 : pat[b+7];
		next_slot();
		drv_chk++;
		if (!dbg_compl) begin
			drv_err++;
			$display("debug access to %h did not complete one cycle after its strobe",
				dbg_addr);
		end
		if (is_read && dbg_rd_val != pat[b+7]) begin
			drv_err++;
			$display("FAIL %0t ns: debug read of %h gave %h, expected %h",
				$time, dbg_addr, dbg_rd_val, pat[b+7]);
		end
		dbg_access = 1'b0;
		dbg_en     = 1'b0;
	endtask

	// Only ldi, move and load retire, three edges after the strobe.
	task automatic note_issue(input int b);
		core_pkg::opcode_t op;
		op = core_pkg::opcode_t'(pat[b+1][2:0]);
		if (op == core_pkg::OP_LDI || op == core_pkg::OP_MOVE ||
			op == core_pkg::OP_LOAD) begin
			exp_q.push_back('{due: cycle + 3, rd: pat[b+2][3:0], value: pat[b+7]});
		end
	endtask

	task automatic check_retire();
		retire_exp_t e;
		while (exp_q.size() > 0 && exp_q[0].due < cycle) begin
			e = exp_q.pop_front();
			ret_err++;
			$display("op for rd %0d never retired, it was due in cycle %0d", e.rd, e.due);
		end
		if (retire_valid) begin
			ret_chk++;
			if (exp_q.size() == 0) begin
				ret_err++;
				$display("retirement of rd %0d at %0t ns belongs to no issued op",
					retire_rd, $time);
			end else begin
				e = exp_q.pop_front();
				if (e.due != cycle || retire_rd != e.rd || retire_value != e.value) begin
					ret_err++;
					$display("FAIL %0t ns: retired rd %0d = %h in cycle %0d, %s %0d = %h in %0d",
						$time, retire_rd, retire_value, cycle, "expected rd",
						e.rd, e.value, e.due);
				end
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			check_retire();
			if (issue_valid) begin
				note_issue(cur_line);
			end
		end
	end

	initial begin
		int cnt;
		int b;
		int n_asrt;
		cnt         = 0;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		dbg_en      = 1'b0;
		dbg_access  = 1'b0;
		dbg_wr_en   = 1'b0;
		dbg_addr    = 32'd0;
		dbg_width   = bus_pkg::W_BYTE;
		dbg_wr_val  = 32'd0;
		$readmemh("verif/lsu_patterns.txt", pat);
		while (cnt < MAX_LINES && pat[cnt*NCOL] != 32'hf) begin
			cnt++;
		end
		n_lines = cnt;
		loaded  = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		next_slot();
		for (int i = 0; i < n_lines; i++) begin
			b        = i * NCOL;
			cur_line = b;
			if (pat[b] == 32'd0) begin
				run_op(b);
			end else begin
				run_debug(b);
			end
			repeat (pat[b+8]) next_slot(); // Idle slots for dependencies.
		end
		repeat (6) next_slot();
		if (n_lines == 0) begin
			drv_err++;
			$display("no pattern lines were read");
		end
		if (exp_q.size() != 0) begin
			drv_err++;
			$display("%0d expected retirements are still outstanding", exp_q.size());
		end
		n_asrt = u_lsu_top.u_lsu_asserts.n_issue_fail + u_lsu_top.u_lsu_asserts.n_unknown_fail +
			u_lsu_top.u_lsu_asserts.n_ack_fail;
		$display("checks %0d, errors %0d, assertion failures %0d",
			drv_chk + ret_chk, drv_err + ret_err, n_asrt);
		if (drv_err + ret_err == 0 && n_asrt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Ten cycles per pattern line is far beyond the longest gap.
	initial begin
		wait (loaded);
		#(n_lines * 10 * CLK_PERIOD + 200);
		$display("watchdog expired at %0t ns before the stimulus finished", $time);
		$display("tests failed");
		$finish;
	end

endmodule
